// File: hdl/ccu_pkg.sv
package ccu_pkg;

    // --------------------------------------------------
    // Widths and buffer sizing
    // --------------------------------------------------
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned DATA_W     = 64;
    localparam int unsigned ID_W       = 4;
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned PTR_W      = 2;

    // AR snoop codes for reads
    localparam logic [3:0] SNP_READ_ONCE     = 4'b0000;
    localparam logic [3:0] SNP_READ_SHARED   = 4'b0001;
    localparam logic [3:0] SNP_READ_CLEAN    = 4'b0010;
    localparam logic [3:0] SNP_READ_UNIQUE   = 4'b0111;
    localparam logic [3:0] SNP_READ_NO_SNOOP = 4'b0000; // Non-shareable or system only

    localparam logic [1:0] DOM_NON_SHARE = 2'b00;
    localparam logic [1:0] DOM_INNER     = 2'b01;
    localparam logic [1:0] DOM_OUTER     = 2'b10;
    localparam logic [1:0] DOM_SYSTEM    = 2'b11;

    // Request classes carried through the FIFO
    localparam logic [1:0] CLS_DIRECT  = 2'b00;
    localparam logic [1:0] CLS_SNOOP   = 2'b01;
    localparam logic [1:0] CLS_ILLEGAL = 2'b10;

    // --------------------------------------------------
    // CR response bits and R response codes
    // --------------------------------------------------
    localparam int unsigned CR_DATA_XFER  = 0;
    localparam int unsigned CR_ERROR      = 1;
    localparam int unsigned CR_PASS_DIRTY = 2;
    localparam int unsigned CR_IS_SHARED  = 3;
    localparam int unsigned CR_WAS_UNIQUE = 4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Snoop controller states
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_SNOOP_AC = 3'd1;
    localparam logic [2:0] ST_SNOOP_CR = 3'd2;
    localparam logic [2:0] ST_SNOOP_CD = 3'd3;
    localparam logic [2:0] ST_MEM_AR   = 3'd4;
    localparam logic [2:0] ST_MEM_R    = 3'd5;
    localparam logic [2:0] ST_RESP     = 3'd6;

endpackage

// File: hdl/ccu_ar_decoder.sv
`timescale 1ns/10ps

module ccu_ar_decoder
    import ccu_pkg::*;
(
    input  logic              rst_n,
    input  logic              arst_n_i,
    input  logic              ar_valid_i,
    input  logic [ADDR_W-1:0] ar_addr_i,
    input  logic [ID_W-1:0]   ar_id_i,
    input  logic [3:0]        ar_snoop_i,
    input  logic [1:0]        ar_domain_i,
    input  logic              full_i,
    output logic              ar_ready_o,
    output logic              push_o,
    output logic [ADDR_W-1:0] push_addr_o,
    output logic [ID_W-1:0]   push_id_o,
    output logic [3:0]        push_snoop_o,
    output logic [1:0]        push_cls_o
);

    logic       stage_valid;
    logic       accept_en;   // Opens AR once reset is gone
    logic       ar_fire;
    logic       dom_direct;
    logic       dom_snoop;
    logic       snp_legal;
    logic [1:0] cls_d;

    // --------------------------------------------------
    // Classification
    // --------------------------------------------------
    assign dom_direct = (ar_domain_i == DOM_NON_SHARE) || (ar_domain_i == DOM_SYSTEM);
    assign dom_snoop  = (ar_domain_i == DOM_INNER) || (ar_domain_i == DOM_OUTER);
    assign snp_legal  = (ar_snoop_i == SNP_READ_ONCE)
                     || (ar_snoop_i == SNP_READ_SHARED)
                     || (ar_snoop_i == SNP_READ_CLEAN)
                     || (ar_snoop_i == SNP_READ_UNIQUE);

    always_comb begin
        if (dom_direct && (ar_snoop_i == SNP_READ_NO_SNOOP)) begin
            cls_d = CLS_DIRECT;
        end else if (dom_snoop && snp_legal) begin
            cls_d = CLS_SNOOP;
        end else begin
            cls_d = CLS_ILLEGAL;
        end
    end

    // --------------------------------------------------
    // One-entry output stage
    // --------------------------------------------------
    assign push_o     = stage_valid && !full_i;
    assign ar_ready_o = accept_en && (!stage_valid || !full_i);
    assign ar_fire    = ar_valid_i && ar_ready_o;

    always_ff @(posedge rst_n or negedge arst_n_i) begin
        if (!arst_n_i) begin
            accept_en   <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            if (ar_fire) begin
                stage_valid <= 1'b1;
            end else if (push_o) begin
                stage_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge rst_n) begin
        if (ar_fire) begin
            push_addr_o  <= ar_addr_i;
            push_id_o    <= ar_id_i;
            push_snoop_o <= ar_snoop_i;
            push_cls_o   <= cls_d;
        end
    end

endmodule

// File: hdl/ccu_req_fifo.sv
`timescale 1ns/10ps

module ccu_req_fifo
    import ccu_pkg::*;
(
    input  logic              rst_n,
    input  logic              arst_n_i,
    input  logic              push_i,
    input  logic [ADDR_W-1:0] push_addr_i,
    input  logic [ID_W-1:0]   push_id_i,
    input  logic [3:0]        push_snoop_i,
    input  logic [1:0]        push_cls_i,
    input  logic              pop_i,
    output logic              full_o,
    output logic              empty_o,
    output logic [ADDR_W-1:0] head_addr_o,
    output logic [ID_W-1:0]   head_id_o,
    output logic [3:0]        head_snoop_o,
    output logic [1:0]        head_cls_o
);

    logic [ADDR_W-1:0] mem_addr  [FIFO_DEPTH];
    logic [ID_W-1:0]   mem_id    [FIFO_DEPTH];
    logic [3:0]        mem_snoop [FIFO_DEPTH];
    logic [1:0]        mem_cls   [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count == FIFO_DEPTH);
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;   // Dropped when full
    assign do_pop  = pop_i && !empty_o;

    assign head_addr_o  = mem_addr[rd_ptr];
    assign head_id_o    = mem_id[rd_ptr];
    assign head_snoop_o = mem_snoop[rd_ptr];
    assign head_cls_o   = mem_cls[rd_ptr];

    always_ff @(posedge rst_n or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at FIFO_DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge rst_n) begin
        if (do_push) begin
            mem_addr[wr_ptr]  <= push_addr_i;
            mem_id[wr_ptr]    <= push_id_i;
            mem_snoop[wr_ptr] <= push_snoop_i;
            mem_cls[wr_ptr]   <= push_cls_i;
        end
    end

endmodule

// File: hdl/ccu_snoop_ctrl.sv
`timescale 1ns/10ps

module ccu_snoop_ctrl
    import ccu_pkg::*;
(
    input  logic              rst_n,
    input  logic              arst_n_i,
    input  logic              empty_i,
    input  logic [ADDR_W-1:0] head_addr_i,
    input  logic [ID_W-1:0]   head_id_i,
    input  logic [3:0]        head_snoop_i,
    input  logic [1:0]        head_cls_i,
    output logic              pop_o,
    output logic              ac_valid_o,
    input  logic              ac_ready_i,
    output logic [ADDR_W-1:0] ac_addr_o,
    output logic [3:0]        ac_snoop_o,
    input  logic              cr_valid_i,
    output logic              cr_ready_o,
    input  logic [4:0]        cr_resp_i,
    input  logic              cd_valid_i,
    output logic              cd_ready_o,
    input  logic [DATA_W-1:0] cd_data_i,
    output logic              mem_ar_valid_o,
    input  logic              mem_ar_ready_i,
    output logic [ADDR_W-1:0] mem_ar_addr_o,
    output logic [ID_W-1:0]   mem_ar_id_o,
    input  logic              mem_r_valid_i,
    output logic              mem_r_ready_o,
    input  logic [DATA_W-1:0] mem_r_data_i,
    input  logic [1:0]        mem_r_resp_i,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    output logic [DATA_W-1:0] r_data_o,
    output logic [ID_W-1:0]   r_id_o,
    output logic [3:0]        r_resp_o,
    output logic              r_last_o
);

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    logic [ADDR_W-1:0] req_addr;
    logic [ID_W-1:0]   req_id;
    logic [3:0]        req_snoop;
    logic [DATA_W-1:0] rsp_data;
    logic [3:0]        rsp_code;   // {IsShared, PassDirty, AXI resp}
    logic              cr_fire;
    logic              cd_fire;
    logic              mem_r_fire;
    logic              cr_hit;
    logic              hit_shared;

    assign pop_o      = (state == ST_IDLE) && !empty_i;
    assign cr_fire    = cr_valid_i && cr_ready_o;
    assign cd_fire    = cd_valid_i && cd_ready_o;
    assign mem_r_fire = mem_r_valid_i && mem_r_ready_o;

    // An error response falls back to memory
    assign cr_hit     = cr_resp_i[CR_DATA_XFER] && !cr_resp_i[CR_ERROR];
    assign hit_shared = cr_resp_i[CR_IS_SHARED] && (req_snoop != SNP_READ_UNIQUE);

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (!empty_i) begin
                    if (head_cls_i == CLS_SNOOP) begin
                        state_nxt = ST_SNOOP_AC;
                    end else if (head_cls_i == CLS_DIRECT) begin
                        state_nxt = ST_MEM_AR;
                    end else begin
                        state_nxt = ST_RESP;   // Illegal, no cache or memory access
                    end
                end
            end
            ST_SNOOP_AC: begin
                if (ac_ready_i) begin
                    state_nxt = ST_SNOOP_CR;
                end
            end
            ST_SNOOP_CR: begin
                if (cr_fire) begin
                    state_nxt = cr_hit ? ST_SNOOP_CD : ST_MEM_AR;
                end
            end
            ST_SNOOP_CD: begin
                if (cd_fire) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_MEM_AR: begin
                if (mem_ar_ready_i) begin
                    state_nxt = ST_MEM_R;
                end
            end
            ST_MEM_R: begin
                if (mem_r_fire) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (r_ready_i) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge rst_n or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------------------------------------
    // Request and response registers
    // --------------------------------------------------
    always_ff @(posedge rst_n) begin
        if (pop_o) begin
            req_addr  <= head_addr_i;
            req_id    <= head_id_i;
            req_snoop <= head_snoop_i;
            rsp_data  <= '0;
            rsp_code  <= {2'b00, RESP_SLVERR};   // Kept only for illegal reads
        end
        if (cr_fire && cr_hit) begin
            rsp_code <= {hit_shared, cr_resp_i[CR_PASS_DIRTY], RESP_OKAY};
        end
        if (cd_fire) begin
            rsp_data <= cd_data_i;
        end
        if (mem_r_fire) begin
            rsp_data <= mem_r_data_i;
            rsp_code <= {2'b00, mem_r_resp_i};
        end
    end

    assign ac_valid_o     = (state == ST_SNOOP_AC);
    assign ac_addr_o      = req_addr;
    assign ac_snoop_o     = req_snoop;
    assign cr_ready_o     = (state == ST_SNOOP_CR);
    assign cd_ready_o     = (state == ST_SNOOP_CD);
    assign mem_ar_valid_o = (state == ST_MEM_AR);
    assign mem_ar_addr_o  = req_addr;
    assign mem_ar_id_o    = req_id;
    assign mem_r_ready_o  = (state == ST_MEM_R);
    assign r_valid_o      = (state == ST_RESP);
    assign r_data_o       = rsp_data;
    assign r_id_o         = req_id;
    assign r_resp_o       = rsp_code;
    assign r_last_o       = 1'b1;   // Single beat

endmodule

// File: hdl/ccu_read_snoop_top.sv
`timescale 1ns/10ps

module ccu_read_snoop_top
    import ccu_pkg::*;
(
    input  logic              rst_n,
    input  logic              arst_n_i,
    // Master AR/R
    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    input  logic [ADDR_W-1:0] ar_addr_i,
    input  logic [ID_W-1:0]   ar_id_i,
    input  logic [3:0]        ar_snoop_i,
    input  logic [1:0]        ar_domain_i,
    output logic              r_valid_o,
    input  logic              r_ready_i,
    output logic [DATA_W-1:0] r_data_o,
    output logic [ID_W-1:0]   r_id_o,
    output logic [3:0]        r_resp_o,
    output logic              r_last_o,
    // Snoop AC/CR/CD
    output logic              ac_valid_o,
    input  logic              ac_ready_i,
    output logic [ADDR_W-1:0] ac_addr_o,
    output logic [3:0]        ac_snoop_o,
    input  logic              cr_valid_i,
    output logic              cr_ready_o,
    input  logic [4:0]        cr_resp_i,
    input  logic              cd_valid_i,
    output logic              cd_ready_o,
    input  logic [DATA_W-1:0] cd_data_i,
    // Memory AR/R
    output logic              mem_ar_valid_o,
    input  logic              mem_ar_ready_i,
    output logic [ADDR_W-1:0] mem_ar_addr_o,
    output logic [ID_W-1:0]   mem_ar_id_o,
    input  logic              mem_r_valid_i,
    output logic              mem_r_ready_o,
    input  logic [DATA_W-1:0] mem_r_data_i,
    input  logic [1:0]        mem_r_resp_i
);

    logic              push;
    logic [ADDR_W-1:0] push_addr;
    logic [ID_W-1:0]   push_id;
    logic [3:0]        push_snoop;
    logic [1:0]        push_cls;
    logic              full;
    logic              empty;
    logic              pop;
    logic [ADDR_W-1:0] head_addr;
    logic [ID_W-1:0]   head_id;
    logic [3:0]        head_snoop;
    logic [1:0]        head_cls;

    ccu_ar_decoder u_decoder (
        .rst_n        (rst_n),
        .arst_n_i     (arst_n_i),
        .ar_valid_i   (ar_valid_i),
        .ar_addr_i    (ar_addr_i),
        .ar_id_i      (ar_id_i),
        .ar_snoop_i   (ar_snoop_i),
        .ar_domain_i  (ar_domain_i),
        .full_i       (full),
        .ar_ready_o   (ar_ready_o),
        .push_o       (push),
        .push_addr_o  (push_addr),
        .push_id_o    (push_id),
        .push_snoop_o (push_snoop),
        .push_cls_o   (push_cls)
    );

    ccu_req_fifo u_fifo (
        .rst_n        (rst_n),
        .arst_n_i     (arst_n_i),
        .push_i       (push),
        .push_addr_i  (push_addr),
        .push_id_i    (push_id),
        .push_snoop_i (push_snoop),
        .push_cls_i   (push_cls),
        .pop_i        (pop),
        .full_o       (full),
        .empty_o      (empty),
        .head_addr_o  (head_addr),
        .head_id_o    (head_id),
        .head_snoop_o (head_snoop),
        .head_cls_o   (head_cls)
    );

    ccu_snoop_ctrl u_ctrl (
        .rst_n          (rst_n),
        .arst_n_i       (arst_n_i),
        .empty_i        (empty),
        .head_addr_i    (head_addr),
        .head_id_i      (head_id),
        .head_snoop_i   (head_snoop),
        .head_cls_i     (head_cls),
        .pop_o          (pop),
        .ac_valid_o     (ac_valid_o),
        .ac_ready_i     (ac_ready_i),
        .ac_addr_o      (ac_addr_o),
        .ac_snoop_o     (ac_snoop_o),
        .cr_valid_i     (cr_valid_i),
        .cr_ready_o     (cr_ready_o),
        .cr_resp_i      (cr_resp_i),
        .cd_valid_i     (cd_valid_i),
        .cd_ready_o     (cd_ready_o),
        .cd_data_i      (cd_data_i),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .mem_ar_id_o    (mem_ar_id_o),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .mem_r_data_i   (mem_r_data_i),
        .mem_r_resp_i   (mem_r_resp_i),
        .r_valid_o      (r_valid_o),
        .r_ready_i      (r_ready_i),
        .r_data_o       (r_data_o),
        .r_id_o         (r_id_o),
        .r_resp_o       (r_resp_o),
        .r_last_o       (r_last_o)
    );

endmodule

// File: testbench/ccu_snoop_ctrl_properties.sv
`timescale 1ns/10ps

module ccu_snoop_ctrl_properties
    import ccu_pkg::*;
(
    input logic              rst_n,
    input logic              arst_n_i,
    input logic              ac_valid_o,
    input logic              ac_ready_i,
    input logic [ADDR_W-1:0] ac_addr_o,
    input logic [3:0]        ac_snoop_o,
    input logic              mem_ar_valid_o,
    input logic              r_valid_o,
    input logic              r_ready_i,
    input logic [DATA_W-1:0] r_data_o,
    input logic [ID_W-1:0]   r_id_o,
    input logic [3:0]        r_resp_o
);

    int unsigned assert_fails = 0;   // Read by the testbench at the end

    ac_hold: assert property (@(posedge rst_n) disable iff (!arst_n_i)
        ac_valid_o && !ac_ready_i |=> ac_valid_o && $stable(ac_addr_o) && $stable(ac_snoop_o))
    else begin
        $error("AC request dropped or changed before ac_ready_i");
        assert_fails++;
    end

    r_hold: assert property (@(posedge rst_n) disable iff (!arst_n_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o)
            && $stable(r_resp_o))
    else begin
        $error("R response dropped or changed before r_ready_i");
        assert_fails++;
    end

    // Snoop and memory phases never overlap
    ac_mem_excl: assert property (@(posedge rst_n) !(ac_valid_o && mem_ar_valid_o))
    else begin
        $error("AC and memory AR valid together");
        assert_fails++;
    end

    quiet_in_reset: assert property (@(posedge rst_n)
        !arst_n_i |-> !ac_valid_o && !mem_ar_valid_o && !r_valid_o)
    else begin
        $error("Output valid high during reset");
        assert_fails++;
    end

endmodule

bind ccu_snoop_ctrl ccu_snoop_ctrl_properties u_props (.*);

// File: testbench/tb_ccu_read_snoop.sv
`timescale 1ns/10ps

module tb_ccu_read_snoop
    import ccu_pkg::*;
();

    localparam logic [31:0] RNG_SEED       = 32'h3ac0331d;
    localparam int          TOTAL_READS    = 20;
    localparam int          TIMEOUT_CYCLES = 40 * TOTAL_READS + 100;

    logic              rst_n;
    logic              arst_n_i;
    logic              ar_valid_i;
    logic              ar_ready_o;
    logic [ADDR_W-1:0] ar_addr_i;
    logic [ID_W-1:0]   ar_id_i;
    logic [3:0]        ar_snoop_i;
    logic [1:0]        ar_domain_i;
    logic              r_valid_o;
    logic              r_ready_i;
    logic [DATA_W-1:0] r_data_o;
    logic [ID_W-1:0]   r_id_o;
    logic [3:0]        r_resp_o;
    logic              r_last_o;
    logic              ac_valid_o;
    logic              ac_ready_i;
    logic [ADDR_W-1:0] ac_addr_o;
    logic [3:0]        ac_snoop_o;
    logic              cr_valid_i;
    logic              cr_ready_o;
    logic [4:0]        cr_resp_i;
    logic              cd_valid_i;
    logic              cd_ready_o;
    logic [DATA_W-1:0] cd_data_i;
    logic              mem_ar_valid_o;
    logic              mem_ar_ready_i;
    logic [ADDR_W-1:0] mem_ar_addr_o;
    logic [ID_W-1:0]   mem_ar_id_o;
    logic              mem_r_valid_i;
    logic              mem_r_ready_o;
    logic [DATA_W-1:0] mem_r_data_i;
    logic [1:0]        mem_r_resp_i;

    logic [31:0]       tb_rng  = RNG_SEED;
    logic [31:0]       rdy_rng = RNG_SEED;
    logic [31:0]       mem_rng = RNG_SEED;
    logic [31:0]       snp_rng = RNG_SEED;
    int                err_count;
    int                ok_tests;
    int                bad_tests;
    int                cycle_cnt;
    int                ac_count;
    int                mem_ar_count;
    logic [ADDR_W-1:0] last_ac_addr;
    logic [3:0]        last_ac_snoop;
    logic [ID_W-1:0]   exp_id   [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [3:0]        exp_resp [$];

    ccu_read_snoop_top uut (.*);

    always #50 rst_n = ~rst_n;

    always @(posedge rst_n) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: no finish after %0d cycles, a handshake never completed",
                     cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return {32'h0, addr} ^ 64'h5a5a_0000_0000_0000;
    endfunction

    function automatic logic [DATA_W-1:0] cache_word(input logic [ADDR_W-1:0] addr);
        return ~{32'h0, addr};
    endfunction

    // Expected R data and response from the read classes
    function automatic void predict(input logic [ADDR_W-1:0] addr, input logic [3:0] snoop,
                                    input logic [1:0] dom, output logic [DATA_W-1:0] data,
                                    output logic [3:0] resp);
        logic direct_dom;
        logic legal_snp;
        direct_dom = (dom == DOM_NON_SHARE) || (dom == DOM_SYSTEM);
        legal_snp  = snoop inside {SNP_READ_ONCE, SNP_READ_SHARED, SNP_READ_CLEAN,
                                   SNP_READ_UNIQUE};
        data = '0;
        resp = {2'b00, RESP_SLVERR};
        if (direct_dom && snoop == SNP_READ_NO_SNOOP) begin
            data = mem_word(addr);
            resp = {2'b00, RESP_OKAY};
        end else if (!direct_dom && legal_snp) begin
            if (addr[6]) begin   // Cache hit
                data = cache_word(addr);
                resp = {(snoop == SNP_READ_UNIQUE) ? 1'b0 : addr[7], addr[8], RESP_OKAY};
            end else begin
                data = mem_word(addr);
                resp = {2'b00, RESP_OKAY};
            end
        end
    endfunction

    task automatic next_cycle();
        @(posedge rst_n);
        #10;
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs0);
        if (err_count == errs0) begin
            ok_tests++;
            $display("%s: ok", name);
        end else begin
            bad_tests++;
            $display("%s: %0d errors", name, err_count - errs0);
        end
    endtask

    task automatic send_ar(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                           input logic [3:0] snoop, input logic [1:0] dom);
        logic [DATA_W-1:0] data;
        logic [3:0]        resp;
        ar_valid_i  = 1'b1;
        ar_addr_i   = addr;
        ar_id_i     = id;
        ar_snoop_i  = snoop;
        ar_domain_i = dom;
        while (!ar_ready_o) begin
            next_cycle();
        end
        next_cycle();   // Accepted at this edge
        ar_valid_i = 1'b0;
        predict(addr, snoop, dom, data, resp);
        exp_id.push_back(id);
        exp_data.push_back(data);
        exp_resp.push_back(resp);
    endtask

    task automatic check_resp();
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [3:0]        resp;
        if (exp_id.size() == 0) begin
            report_error("R response arrived with no read outstanding");
        end else begin
            id   = exp_id.pop_front();
            data = exp_data.pop_front();
            resp = exp_resp.pop_front();
            if (r_id_o !== id) begin
                report_mismatch($sformatf("r_id expected %h got %h", id, r_id_o));
            end
            if (r_data_o !== data) begin
                report_mismatch($sformatf("r_data expected %h got %h", data, r_data_o));
            end
            if (r_resp_o !== resp) begin
                report_mismatch($sformatf("r_resp expected %b got %b", resp, r_resp_o));
            end
            if (r_last_o !== 1'b1) begin
                report_mismatch("r_last expected 1 got 0");
            end
        end
    endtask

    task automatic recv_resps(input int n, input bit toggle);
        int got;
        got = 0;
        while (got < n) begin
            rdy_rng   = xorshift(rdy_rng);
            r_ready_i = toggle ? rdy_rng[0] : 1'b1;
            if (r_valid_o && r_ready_i) begin
                check_resp();
                got++;
            end
            next_cycle();
        end
        r_ready_i = 1'b0;
    endtask

    task automatic check_counts(input int ac_exp, input int mem_exp);
        if (ac_count != ac_exp) begin
            report_mismatch($sformatf("AC count expected %0d got %0d", ac_exp, ac_count));
        end
        if (mem_ar_count != mem_exp) begin
            report_mismatch($sformatf("memory AR count expected %0d got %0d",
                                      mem_exp, mem_ar_count));
        end
    endtask

    task automatic snoop_read(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                              input logic [3:0] snoop, input logic [1:0] dom,
                              input int mem_delta);
        int ac0;
        int mem0;
        ac0  = ac_count;
        mem0 = mem_ar_count;
        send_ar(addr, id, snoop, dom);
        recv_resps(1, 1'b0);
        check_counts(ac0 + 1, mem0 + mem_delta);
        if (last_ac_addr !== addr || last_ac_snoop !== snoop) begin
            report_mismatch($sformatf("AC expected %h/%b got %h/%b", addr, snoop,
                                      last_ac_addr, last_ac_snoop));
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_direct();
        int errs0;
        int ac0;
        int mem0;
        errs0 = err_count;
        ac0   = ac_count;
        mem0  = mem_ar_count;
        send_ar(32'h0000_1234, 4'h3, SNP_READ_NO_SNOOP, DOM_NON_SHARE);
        recv_resps(1, 1'b0);
        check_counts(ac0, mem0 + 1);
        finish_test("direct read", errs0);
    endtask

    task automatic test_snoop_miss();
        int errs0;
        errs0 = err_count;
        snoop_read(32'h0000_2000, 4'h5, SNP_READ_ONCE, DOM_INNER, 1);
        snoop_read(32'h0000_2088, 4'h6, SNP_READ_SHARED, DOM_OUTER, 1);   // Bit 6 clear
        finish_test("snoop miss", errs0);
    endtask

    task automatic test_snoop_hit();
        int errs0;
        errs0 = err_count;
        snoop_read(32'h0000_30c0, 4'h7, SNP_READ_SHARED, DOM_INNER, 0);
        snoop_read(32'h0000_3140, 4'h8, SNP_READ_CLEAN, DOM_OUTER, 0);
        snoop_read(32'h0000_31c0, 4'h9, SNP_READ_UNIQUE, DOM_INNER, 0);   // IsShared dropped
        finish_test("snoop hit", errs0);
    endtask

    task automatic test_illegal();
        int errs0;
        int ac0;
        int mem0;
        errs0 = err_count;
        ac0   = ac_count;
        mem0  = mem_ar_count;
        send_ar(32'h0000_40c0, 4'ha, SNP_READ_SHARED, DOM_SYSTEM);
        recv_resps(1, 1'b0);
        send_ar(32'h0000_4040, 4'hb, 4'b0100, DOM_INNER);
        recv_resps(1, 1'b0);
        check_counts(ac0, mem0);
        finish_test("illegal read", errs0);
    endtask

    task automatic test_ordering();
        int errs0;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [3:0]        snoop;
        logic [1:0]        dom;
        errs0 = err_count;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    tb_rng = xorshift(tb_rng);
                    addr   = tb_rng;
                    tb_rng = xorshift(tb_rng);
                    id     = tb_rng[3:0];
                    dom    = tb_rng[5:4];
                    case (tb_rng[10:8])
                        3'd0, 3'd1: snoop = SNP_READ_ONCE;
                        3'd2:       snoop = SNP_READ_SHARED;
                        3'd3:       snoop = SNP_READ_CLEAN;
                        3'd4, 3'd5: snoop = SNP_READ_UNIQUE;
                        default:    snoop = 4'b0100;
                    endcase
                    send_ar(addr, id, snoop, dom);
                end
            end
            recv_resps(12, 1'b1);
        join
        r_ready_i = 1'b1;
        repeat (5) begin
            next_cycle();
            if (r_valid_o) begin
                report_error("extra R response after all reads were answered");
            end
        end
        r_ready_i = 1'b0;
        finish_test("ordering under back-pressure", errs0);
    endtask

    // --------------------------------------------------
    // Memory and snoop-cache models
    // --------------------------------------------------
    initial begin : memory_model
        logic [ADDR_W-1:0] addr;
        int unsigned       delay;
        forever begin
            next_cycle();
            if (mem_ar_valid_o) begin
                mem_rng = xorshift(mem_rng);
                delay   = mem_rng % 4;
                repeat (delay) next_cycle();
                addr           = mem_ar_addr_o;
                // Oldest unanswered read owns the memory access
                if (exp_id.size() == 0) begin
                    report_error("memory AR issued with no read outstanding");
                end else if (mem_ar_id_o !== exp_id[0]) begin
                    report_mismatch($sformatf("mem_ar_id expected %h got %h", exp_id[0],
                                              mem_ar_id_o));
                end
                mem_ar_ready_i = 1'b1;
                next_cycle();
                mem_ar_ready_i = 1'b0;
                mem_ar_count++;
                mem_r_valid_i = 1'b1;
                mem_r_data_i  = mem_word(addr);
                mem_r_resp_i  = RESP_OKAY;
                while (!mem_r_ready_o) begin
                    next_cycle();
                end
                next_cycle();
                mem_r_valid_i = 1'b0;
            end
        end
    end

    initial begin : snoop_cache_model
        logic [ADDR_W-1:0] addr;
        int unsigned       delay;
        forever begin
            next_cycle();
            if (ac_valid_o) begin
                snp_rng = xorshift(snp_rng);
                delay   = snp_rng % 4;
                repeat (delay) next_cycle();
                addr          = ac_addr_o;
                last_ac_addr  = ac_addr_o;
                last_ac_snoop = ac_snoop_o;
                ac_ready_i    = 1'b1;
                next_cycle();
                ac_ready_i = 1'b0;
                ac_count++;
                cr_valid_i = 1'b1;
                cr_resp_i  = addr[6] ? {1'b0, addr[7], addr[8], 1'b0, 1'b1} : 5'b0;
                while (!cr_ready_o) begin
                    next_cycle();
                end
                next_cycle();
                cr_valid_i = 1'b0;
                if (addr[6]) begin   // Hit carries data on CD
                    cd_valid_i = 1'b1;
                    cd_data_i  = cache_word(addr);
                    while (!cd_ready_o) begin
                        next_cycle();
                    end
                    next_cycle();
                    cd_valid_i = 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst_n          = 1'b0;
        arst_n_i       = 1'b0;
        ar_valid_i     = 1'b0;
        ar_addr_i      = '0;
        ar_id_i        = '0;
        ar_snoop_i     = '0;
        ar_domain_i    = '0;
        r_ready_i      = 1'b0;
        ac_ready_i     = 1'b0;
        cr_valid_i     = 1'b0;
        cr_resp_i      = '0;
        cd_valid_i     = 1'b0;
        cd_data_i      = '0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_data_i   = '0;
        mem_r_resp_i   = '0;
        repeat (5) @(posedge rst_n);
        #10;
        arst_n_i = 1'b1;
        next_cycle();
        test_direct();
        test_snoop_miss();
        test_snoop_hit();
        test_illegal();
        test_ordering();
        if (uut.u_ctrl.u_props.assert_fails != 0) begin
            report_error("controller assertions failed during the run");
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in all",
                 ok_tests, bad_tests, err_count);
        if (bad_tests == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hdl/ccu_pkg.sv
hdl/ccu_ar_decoder.sv
hdl/ccu_req_fifo.sv
hdl/ccu_snoop_ctrl.sv
hdl/ccu_read_snoop_top.sv
testbench/ccu_snoop_ctrl_properties.sv
testbench/tb_ccu_read_snoop.sv
